/* list.f */
+incdir+verification
logic/periph_pkg.sv
logic/gpio_regs.sv
logic/uart_regs.sv
logic/uart_tx.sv
logic/periph_top.sv
verification/tb_periph.sv

/* logic/gpio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  wire                         i_mclk,
    input  wire                         i_rst,
    input  wire periph_pkg::addr_t      i_per_addr,
    input  wire periph_pkg::data_t      i_per_din,
    input  wire                         i_per_en,
    input  wire periph_pkg::we_t        i_per_we,
    input  wire periph_pkg::byte_t      i_port0_in,
    input  wire periph_pkg::byte_t      i_port1_in,
    output periph_pkg::data_t           o_per_dout,
    output periph_pkg::byte_t           o_port0_dir,
    output periph_pkg::byte_t           o_port0_out,
    output periph_pkg::byte_t           o_port1_dir,
    output periph_pkg::byte_t           o_port1_out
);

    // Port p lives in byte lane p
    logic [periph_pkg::PER_BW-1:0][7:0] dir_q;      // Direction latches
    logic [periph_pkg::PER_BW-1:0][7:0] out_q;      // Output latches
    logic [periph_pkg::PER_BW-1:0][7:0] pins_in;    // Raw pin inputs
    logic [periph_pkg::PER_BW-1:0][7:0] pin_val;    // Value seen on read

    logic [periph_pkg::SYNC_STAGES-1:0][periph_pkg::PER_BW-1:0][7:0] sync_q;

    logic sel_in;
    logic sel_out;
    logic sel_dir;
    logic wr_en;
    logic rd_en;

    // ------------------------------------------------
    // Address decode
    // ------------------------------------------------
    assign sel_in  = i_per_addr == periph_pkg::addr_t'(periph_pkg::GPIO_BASE
                                                       + periph_pkg::GPIO_IN_OFS);
    assign sel_out = i_per_addr == periph_pkg::addr_t'(periph_pkg::GPIO_BASE
                                                       + periph_pkg::GPIO_OUT_OFS);
    assign sel_dir = i_per_addr == periph_pkg::addr_t'(periph_pkg::GPIO_BASE
                                                       + periph_pkg::GPIO_DIR_OFS);

    assign wr_en = i_per_en && (|i_per_we);         // Any lane enabled
    assign rd_en = i_per_en && !(|i_per_we);

    // ------------------------------------------------
    // Direction and output latches
    // ------------------------------------------------
    always_ff @(posedge i_mclk) begin
        if (i_rst) begin
            dir_q <= '0;                            // All pins input
            out_q <= '0;
        end else if (wr_en) begin
            for (int p = 0; p < periph_pkg::PER_BW; p++) begin
                if (i_per_we[p] && sel_out) begin
                    out_q[p] <= i_per_din[p*8 +: 8];
                end
                if (i_per_we[p] && sel_dir) begin
                    dir_q[p] <= i_per_din[p*8 +: 8];
                end
            end
        end
    end

    // Input synchronizer, oldest stage on top
    assign pins_in = {i_port1_in, i_port0_in};

    always_ff @(posedge i_mclk) begin
        sync_q <= {sync_q[periph_pkg::SYNC_STAGES-2:0], pins_in};
    end

    // Latch for output pins, synchronized pin otherwise
    assign pin_val = (dir_q & out_q) | (~dir_q & sync_q[periph_pkg::SYNC_STAGES-1]);

    // ------------------------------------------------
    // Read data
    // ------------------------------------------------
    always_comb begin
        o_per_dout = '0;                            // Quiet when not addressed
        if (rd_en) begin
            if (sel_in) begin
                o_per_dout = pin_val;
            end else if (sel_out) begin
                o_per_dout = out_q;
            end else if (sel_dir) begin
                o_per_dout = dir_q;
            end
        end
    end

    assign o_port0_dir = dir_q[0];
    assign o_port0_out = out_q[0];
    assign o_port1_dir = dir_q[1];
    assign o_port1_out = out_q[1];

    // Shared OR bus needs silence outside the GPIO window
    a_dout_quiet : assert property (@(posedge i_mclk) disable iff (i_rst)
        !(i_per_en && (sel_in || sel_out || sel_dir)) |-> o_per_dout == '0);

endmodule

`default_nettype wire

/* logic/periph_pkg.sv */
`default_nettype none

package periph_pkg;

    // ------------------------------------------------
    // Peripheral bus
    // ------------------------------------------------
    localparam int PER_AW = 14;                     // Word address width
    localparam int PER_DW = 16;                     // Data width
    localparam int PER_BW = 2;                      // One enable per byte lane

    typedef logic [PER_AW-1:0] addr_t;
    typedef logic [PER_DW-1:0] data_t;
    typedef logic [PER_BW-1:0] we_t;
    typedef logic [7:0]        byte_t;              // Port or character

    // ------------------------------------------------
    // Address map
    // ------------------------------------------------
    // GPIO block, one byte lane per port
    localparam addr_t GPIO_BASE    = 14'h0010;
    localparam addr_t GPIO_IN_OFS  = 14'd0;         // Read only, pin state
    localparam addr_t GPIO_OUT_OFS = 14'd1;         // Output latches
    localparam addr_t GPIO_DIR_OFS = 14'd2;         // 1 = output

    // UART transmitter block
    localparam addr_t UART_BASE     = 14'h0018;
    localparam addr_t UART_PRER_OFS = 14'd0;        // Bit period minus one
    localparam addr_t UART_TXD_OFS  = 14'd1;        // Low byte sent
    localparam addr_t UART_STAT_OFS = 14'd2;        // Busy and done

    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;               // Sticky, write 1 clears

    // ------------------------------------------------
    // UART frame and misc
    // ------------------------------------------------
    localparam int UART_FRAME_BITS = 10;            // Start, 8 data, stop
    localparam int UART_CNT_W      = $clog2(UART_FRAME_BITS);

    localparam int SYNC_STAGES = 2;                 // Input synchronizer depth

endpackage

`default_nettype wire

/* logic/periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  wire                         i_mclk,
    input  wire                         i_rst,

    // Peripheral bus
    input  wire periph_pkg::addr_t      i_per_addr,
    input  wire periph_pkg::data_t      i_per_din,
    input  wire                         i_per_en,
    input  wire periph_pkg::we_t        i_per_we,
    output periph_pkg::data_t           o_per_dout,

    // GPIO pins, pads outside
    input  wire periph_pkg::byte_t      i_port0_in,
    input  wire periph_pkg::byte_t      i_port1_in,
    output periph_pkg::byte_t           o_port0_dir,
    output periph_pkg::byte_t           o_port0_out,
    output periph_pkg::byte_t           o_port1_dir,
    output periph_pkg::byte_t           o_port1_out,

    output logic                        o_uart_txd
);

    periph_pkg::data_t per_dout_gpio;
    periph_pkg::data_t per_dout_uart;

    logic              uart_start;
    periph_pkg::byte_t uart_txbyte;
    periph_pkg::data_t uart_prer;
    logic              uart_busy;
    logic              uart_done;

    // ------------------------------------------------
    // GPIO
    // ------------------------------------------------
    gpio_regs m_gpio_regs0 (
        .i_mclk      (i_mclk),
        .i_rst       (i_rst),
        .i_per_addr  (i_per_addr),
        .i_per_din   (i_per_din),
        .i_per_en    (i_per_en),
        .i_per_we    (i_per_we),
        .i_port0_in  (i_port0_in),
        .i_port1_in  (i_port1_in),
        .o_per_dout  (per_dout_gpio),
        .o_port0_dir (o_port0_dir),         // 1 = output
        .o_port0_out (o_port0_out),
        .o_port1_dir (o_port1_dir),         // 1 = output
        .o_port1_out (o_port1_out)
    );

    // ------------------------------------------------
    // UART transmitter
    // ------------------------------------------------
    uart_regs m_uart_regs0 (
        .i_mclk      (i_mclk),
        .i_rst       (i_rst),
        .i_per_addr  (i_per_addr),
        .i_per_din   (i_per_din),
        .i_per_en    (i_per_en),
        .i_per_we    (i_per_we),
        .i_busy      (uart_busy),
        .i_done      (uart_done),
        .o_per_dout  (per_dout_uart),
        .o_start     (uart_start),          // Only while idle
        .o_txbyte    (uart_txbyte),
        .o_prer      (uart_prer)
    );

    uart_tx m_uart_tx0 (
        .i_mclk      (i_mclk),
        .i_rst       (i_rst),
        .i_start     (uart_start),
        .i_txbyte    (uart_txbyte),
        .i_prer      (uart_prer),
        .o_busy      (uart_busy),
        .o_done      (uart_done),           // Sets sticky flag
        .o_txd       (o_uart_txd)
    );

    // Slave read data, each zero when not addressed
    assign o_per_dout = per_dout_gpio | per_dout_uart;

endmodule

`default_nettype wire

/* logic/uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  wire                         i_mclk,
    input  wire                         i_rst,
    input  wire periph_pkg::addr_t      i_per_addr,
    input  wire periph_pkg::data_t      i_per_din,
    input  wire                         i_per_en,
    input  wire periph_pkg::we_t        i_per_we,
    input  wire                         i_busy,     // Serializer running
    input  wire                         i_done,     // End of stop bit
    output periph_pkg::data_t           o_per_dout,
    output logic                        o_start,
    output periph_pkg::byte_t           o_txbyte,
    output periph_pkg::data_t           o_prer
);

    periph_pkg::data_t prer_q;                      // Bit period minus one
    periph_pkg::byte_t txd_q;                       // Accepted character
    periph_pkg::data_t stat_word;

    logic start_q;                                  // One cycle after accept
    logic done_q;                                   // Sticky frame done
    logic busy_rd;

    logic sel_prer;
    logic sel_txd;
    logic sel_stat;
    logic wr_en;
    logic rd_en;
    logic accept;
    logic done_clr;

    // ------------------------------------------------
    // Address decode
    // ------------------------------------------------
    assign sel_prer = i_per_addr == periph_pkg::addr_t'(periph_pkg::UART_BASE
                                                        + periph_pkg::UART_PRER_OFS);
    assign sel_txd  = i_per_addr == periph_pkg::addr_t'(periph_pkg::UART_BASE
                                                        + periph_pkg::UART_TXD_OFS);
    assign sel_stat = i_per_addr == periph_pkg::addr_t'(periph_pkg::UART_BASE
                                                        + periph_pkg::UART_STAT_OFS);

    assign wr_en = i_per_en && (|i_per_we);
    assign rd_en = i_per_en && !(|i_per_we);

    // Pending start counts as busy so a back-to-back write is dropped
    assign accept   = wr_en && sel_txd && i_per_we[0] && !i_busy && !start_q;
    assign done_clr = wr_en && sel_stat && i_per_we[0]
                      && i_per_din[periph_pkg::STAT_DONE_BIT];

    // ------------------------------------------------
    // Control registers
    // ------------------------------------------------
    always_ff @(posedge i_mclk) begin
        if (i_rst) begin
            prer_q  <= '0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= accept;                      // Single-cycle pulse
            for (int b = 0; b < periph_pkg::PER_BW; b++) begin
                if (wr_en && sel_prer && i_per_we[b]) begin
                    prer_q[b*8 +: 8] <= i_per_din[b*8 +: 8];
                end
            end
            if (i_done) begin
                done_q <= 1'b1;                     // New event beats clear
            end else if (done_clr) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_mclk) begin
        if (accept) begin
            txd_q <= i_per_din[7:0];                // Writes during busy lost
        end
    end

    // ------------------------------------------------
    // Read data
    // ------------------------------------------------
    assign busy_rd = i_busy || start_q;

    always_comb begin
        stat_word = '0;
        stat_word[periph_pkg::STAT_BUSY_BIT] = busy_rd;
        stat_word[periph_pkg::STAT_DONE_BIT] = done_q;
    end

    always_comb begin
        o_per_dout = '0;
        if (rd_en) begin
            if (sel_prer) begin
                o_per_dout = prer_q;
            end else if (sel_txd) begin
                o_per_dout = {8'h00, txd_q};        // Character in low byte
            end else if (sel_stat) begin
                o_per_dout = stat_word;
            end
        end
    end

    assign o_start  = start_q;
    assign o_txbyte = txd_q;
    assign o_prer   = prer_q;

    // Start must never reach a running serializer
    a_no_start_busy : assert property (@(posedge i_mclk) disable iff (i_rst)
        !(o_start && i_busy));

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                         i_mclk,
    input  wire                         i_rst,
    input  wire                         i_start,    // One-cycle kick
    input  wire periph_pkg::byte_t      i_txbyte,
    input  wire periph_pkg::data_t      i_prer,
    output logic                        o_busy,
    output logic                        o_done,
    output logic                        o_txd
);

    localparam int SHIFT_W = periph_pkg::UART_FRAME_BITS - 1;

    // Payload, latched at start
    logic [SHIFT_W-1:0]  shift_q;                   // Data then stop bit
    periph_pkg::data_t   prer_q;

    // Control
    logic                busy_q;
    logic                txd_q;
    periph_pkg::data_t   baud_q;                    // Cycles left in bit
    logic [periph_pkg::UART_CNT_W-1:0] bit_q;       // Bit index in frame

    logic                launch;
    logic                bit_end;
    logic                last_bit;

    // ------------------------------------------------
    // Bit timing
    // ------------------------------------------------
    assign launch   = i_start && !busy_q;
    assign bit_end  = busy_q && (baud_q == '0);
    assign last_bit = bit_q == periph_pkg::UART_CNT_W'(periph_pkg::UART_FRAME_BITS - 1);

    always_ff @(posedge i_mclk) begin
        if (i_rst) begin
            busy_q <= 1'b0;
            txd_q  <= 1'b1;                         // Line idles high
            baud_q <= '0;
            bit_q  <= '0;
        end else if (launch) begin
            busy_q <= 1'b1;
            txd_q  <= 1'b0;                         // Start bit
            baud_q <= i_prer;
            bit_q  <= '0;
        end else if (bit_end) begin
            if (last_bit) begin
                busy_q <= 1'b0;                     // Stop bit finished
                txd_q  <= 1'b1;
            end else begin
                txd_q  <= shift_q[0];               // LSB first
                bit_q  <= bit_q + 1'b1;
                baud_q <= prer_q;                   // Reload period
            end
        end else if (busy_q) begin
            baud_q <= baud_q - 1'b1;
        end
    end

    // ------------------------------------------------
    // Shift register
    // ------------------------------------------------
    always_ff @(posedge i_mclk) begin
        if (launch) begin
            shift_q <= {1'b1, i_txbyte};            // Stop bit on top
            prer_q  <= i_prer;
        end else if (bit_end) begin
            shift_q <= {1'b1, shift_q[SHIFT_W-1:1]};
        end
    end

    // Pulse in last cycle of stop bit
    assign o_done = bit_end && last_bit;
    assign o_busy = busy_q;
    assign o_txd  = txd_q;

    // Idle line must sit at mark level
    a_idle_high : assert property (@(posedge i_mclk) disable iff (i_rst)
        !o_busy |-> o_txd);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the peripheral testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_periph -f list.f -o sim_periph

# The log decides the result, a crashed run leaves no pass line
./obj_dir/sim_periph | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "run.sh: simulation reported success"
else
    echo "run.sh: simulation reported failure"
    exit 1
fi

/* verification/tb_periph_checks.svh */
`ifndef TB_PERIPH_CHECKS_SVH
`define TB_PERIPH_CHECKS_SVH

// --------------------------------------------------
// Model state and bookkeeping
// --------------------------------------------------
periph_pkg::data_t m_dir;                           // Lane p is port p
periph_pkg::data_t m_out;
periph_pkg::data_t m_pins;                          // Levels driven on pins
periph_pkg::data_t m_prer;
periph_pkg::byte_t m_txd;                           // Last accepted char
logic              m_busy;
logic              m_done;                          // Sticky

int unsigned lcg_state = 13;
int          err_count;
int          check_count;
string       cur_test;

string             cmp_name_q[$];                   // Pending comparisons
int                cmp_kind_q[$];
periph_pkg::data_t cmp_exp_q[$];
periph_pkg::data_t cmp_act_q[$];

localparam int K_DATA = 0;
localparam int K_BYTE = 1;
localparam int K_BIT  = 2;

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;                          // Low bits are weak
endfunction

// --------------------------------------------------
// Reference model that updates its state on writes
// --------------------------------------------------
function automatic periph_pkg::data_t periph_model(input logic wr,
                                                   input periph_pkg::addr_t addr,
                                                   input periph_pkg::data_t din,
                                                   input periph_pkg::we_t we);
    periph_pkg::data_t mask;
    periph_pkg::data_t rd;
    mask = {{8{we[1]}}, {8{we[0]}}};                // Byte-lane merge
    rd   = '0;
    if (wr) begin
        case (addr)
            A_GPIO_OUT:  m_out  = (m_out & ~mask) | (din & mask);
            A_GPIO_DIR:  m_dir  = (m_dir & ~mask) | (din & mask);
            A_UART_PRER: m_prer = (m_prer & ~mask) | (din & mask);
            A_UART_TXD: begin
                if (we[0] && !m_busy) begin         // Dropped while busy
                    m_txd  = din[7:0];
                    m_busy = 1'b1;
                end
            end
            A_UART_STAT: begin
                if (we[0] && din[periph_pkg::STAT_DONE_BIT]) begin
                    m_done = 1'b0;                  // Write 1 clears
                end
            end
            default: ;
        endcase
    end else begin
        case (addr)
            A_GPIO_IN: begin
                for (int b = 0; b < periph_pkg::PER_DW; b++) begin
                    rd[b] = m_dir[b] ? m_out[b] : m_pins[b];    // Output pin shows latch
                end
            end
            A_GPIO_OUT:  rd = m_out;
            A_GPIO_DIR:  rd = m_dir;
            A_UART_PRER: rd = m_prer;
            A_UART_TXD:  rd = {8'h00, m_txd};
            A_UART_STAT: begin
                rd[periph_pkg::STAT_BUSY_BIT] = m_busy;
                rd[periph_pkg::STAT_DONE_BIT] = m_done;
            end
            default:     rd = '0;                   // Unmapped
        endcase
    end
    return rd;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_data(input string name, input periph_pkg::data_t exp,
                          input periph_pkg::data_t act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_byte(input string name, input periph_pkg::byte_t exp,
                          input periph_pkg::byte_t act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("ERR %s expected %b actual %b", name, exp, act);
    end
endtask

task automatic queue_check(input string label, input int kind,
                           input periph_pkg::data_t exp, input periph_pkg::data_t act);
    cmp_name_q.push_back({cur_test, ":", label});
    cmp_kind_q.push_back(kind);
    cmp_exp_q.push_back(exp);
    cmp_act_q.push_back(act);
endtask

// Finds the start bit, then samples each bit in its middle
task automatic sample_frame(input int prer, input int limit, output periph_pkg::byte_t data,
                            output logic start_b, output logic stop_b, output logic found);
    logic [periph_pkg::UART_FRAME_BITS-1:0] bits;
    int                                     waited;
    bits   = '1;
    found  = 1'b0;
    waited = 0;
    while (!found && waited < limit) begin
        @(negedge i_mclk);
        found = (o_uart_txd === 1'b0);
        waited++;
    end
    if (found) begin
        repeat ((prer + 1) / 2) @(negedge i_mclk);  // Mid start bit
        bits[0] = o_uart_txd;
        for (int i = 1; i < periph_pkg::UART_FRAME_BITS; i++) begin
            repeat (prer + 1) @(negedge i_mclk);
            bits[i] = o_uart_txd;
        end
    end
    start_b = bits[0];
    data    = bits[8:1];                            // LSB first on the line
    stop_b  = bits[periph_pkg::UART_FRAME_BITS-1];
endtask

`endif

/* verification/tb_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_periph;

    localparam int N_GPIO_WR = 24;
    localparam int N_GPIO_IN = 8;
    localparam int T4_FRAMES = 4;
    localparam int T4_PRER   = 4;
    localparam int T5_FRAMES = 1;                   // Second write is dropped
    localparam int T5_PRER   = 7;
    localparam int WD_CYCLES = periph_pkg::UART_FRAME_BITS
                               * (T4_FRAMES * (T4_PRER + 1) + T5_FRAMES * (T5_PRER + 1))
                               + 2000;

    localparam periph_pkg::addr_t A_GPIO_IN   = periph_pkg::GPIO_BASE
                                                + periph_pkg::GPIO_IN_OFS;
    localparam periph_pkg::addr_t A_GPIO_OUT  = periph_pkg::GPIO_BASE
                                                + periph_pkg::GPIO_OUT_OFS;
    localparam periph_pkg::addr_t A_GPIO_DIR  = periph_pkg::GPIO_BASE
                                                + periph_pkg::GPIO_DIR_OFS;
    localparam periph_pkg::addr_t A_UART_PRER = periph_pkg::UART_BASE
                                                + periph_pkg::UART_PRER_OFS;
    localparam periph_pkg::addr_t A_UART_TXD  = periph_pkg::UART_BASE
                                                + periph_pkg::UART_TXD_OFS;
    localparam periph_pkg::addr_t A_UART_STAT = periph_pkg::UART_BASE
                                                + periph_pkg::UART_STAT_OFS;

    logic              i_mclk;
    logic              i_rst;
    periph_pkg::addr_t i_per_addr;
    periph_pkg::data_t i_per_din;
    logic              i_per_en;
    periph_pkg::we_t   i_per_we;
    periph_pkg::data_t o_per_dout;
    periph_pkg::byte_t i_port0_in;
    periph_pkg::byte_t i_port1_in;
    periph_pkg::byte_t o_port0_dir;
    periph_pkg::byte_t o_port0_out;
    periph_pkg::byte_t o_port1_dir;
    periph_pkg::byte_t o_port1_out;
    logic              o_uart_txd;

    int test_count;
    int test_err_mark;

    periph_top dut0 (
        .i_mclk      (i_mclk),
        .i_rst       (i_rst),
        .i_per_addr  (i_per_addr),
        .i_per_din   (i_per_din),
        .i_per_en    (i_per_en),
        .i_per_we    (i_per_we),
        .o_per_dout  (o_per_dout),
        .i_port0_in  (i_port0_in),
        .i_port1_in  (i_port1_in),
        .o_port0_dir (o_port0_dir),
        .o_port0_out (o_port0_out),
        .o_port1_dir (o_port1_dir),
        .o_port1_out (o_port1_out),
        .o_uart_txd  (o_uart_txd)
    );

    `include "tb_periph_checks.svh"

    initial begin
        i_mclk = 1'b0;
        forever #50 i_mclk = ~i_mclk;               // 100 ns period
    end

    initial begin
        repeat (WD_CYCLES) @(posedge i_mclk);
        $display("watchdog: run did not finish within %0d cycles", WD_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // Comparator, drains queued checks mid-cycle
    always @(negedge i_mclk) begin : compare_proc
        string             name;
        int                kind;
        periph_pkg::data_t exp_v;
        periph_pkg::data_t act_v;
        while (cmp_kind_q.size() > 0) begin
            name  = cmp_name_q.pop_front();
            kind  = cmp_kind_q.pop_front();
            exp_v = cmp_exp_q.pop_front();
            act_v = cmp_act_q.pop_front();
            case (kind)
                K_DATA:  check_data(name, exp_v, act_v);
                K_BYTE:  check_byte(name, exp_v[7:0], act_v[7:0]);
                default: check_bit(name, exp_v[0], act_v[0]);
            endcase
        end
    end

    // --------------------------------------------------
    // Bus and pin tasks
    // --------------------------------------------------
    task automatic bus_write(input periph_pkg::addr_t addr, input periph_pkg::data_t din,
                             input periph_pkg::we_t we);
        @(posedge i_mclk);
        #5;
        i_per_addr = addr;
        i_per_din  = din;
        i_per_we   = we;
        i_per_en   = 1'b1;
        @(posedge i_mclk);                          // Write edge
        #5;
        i_per_en   = 1'b0;
        i_per_we   = '0;
    endtask

    task automatic bus_read(input periph_pkg::addr_t addr, output periph_pkg::data_t data);
        @(posedge i_mclk);
        #5;
        i_per_addr = addr;
        i_per_we   = '0;
        i_per_en   = 1'b1;
        @(negedge i_mclk);
        data = o_per_dout;                          // Combinational read
        @(posedge i_mclk);
        #5;
        i_per_en   = 1'b0;
    endtask

    task automatic read_check(input periph_pkg::addr_t addr, input string label);
        periph_pkg::data_t rd;
        bus_read(addr, rd);
        queue_check(label, K_DATA, periph_model(1'b0, addr, '0, '0), rd);
    endtask

    task automatic model_write(input periph_pkg::addr_t addr, input periph_pkg::data_t din,
                               input periph_pkg::we_t we);
        bus_write(addr, din, we);
        void'(periph_model(1'b1, addr, din, we));
    endtask

    task automatic drive_pins(input periph_pkg::byte_t p0, input periph_pkg::byte_t p1);
        @(posedge i_mclk);
        #5;
        i_port0_in = p0;
        i_port1_in = p1;
        m_pins     = {p1, p0};
    endtask

    task automatic check_ports();
        queue_check("port0_dir", K_BYTE, {8'h00, m_dir[7:0]}, {8'h00, o_port0_dir});
        queue_check("port0_out", K_BYTE, {8'h00, m_out[7:0]}, {8'h00, o_port0_out});
        queue_check("port1_dir", K_BYTE, {8'h00, m_dir[15:8]}, {8'h00, o_port1_dir});
        queue_check("port1_out", K_BYTE, {8'h00, m_out[15:8]}, {8'h00, o_port1_out});
    endtask

    task automatic wait_idle(input int max_polls);
        periph_pkg::data_t st;
        int                polls;
        st    = '1;                                 // Busy until read
        polls = 0;
        while (st[periph_pkg::STAT_BUSY_BIT] !== 1'b0 && polls < max_polls) begin
            bus_read(A_UART_STAT, st);
            polls++;
        end
        if (st[periph_pkg::STAT_BUSY_BIT] !== 1'b0) begin
            err_count++;
            $display("%s: UART still busy after %0d status polls", cur_test, polls);
        end
    endtask

    // One frame, optional second write while busy
    task automatic uart_frame(input periph_pkg::byte_t ch, input logic extra,
                              input periph_pkg::byte_t ch2, input int prer);
        periph_pkg::byte_t got;
        logic              start_b;
        logic              stop_b;
        logic              found;
        fork
            sample_frame(prer, 40, got, start_b, stop_b, found);
            begin
                model_write(A_UART_TXD, {8'h00, ch}, 2'b01);
                if (extra) begin
                    model_write(A_UART_TXD, {8'h00, ch2}, 2'b01);
                end
                read_check(A_UART_STAT, "stat_busy");
            end
        join
        if (!found) begin
            err_count++;
            $display("%s: no start bit seen on o_uart_txd", cur_test);
        end else begin
            queue_check("start_bit", K_BIT, 16'd0, {15'd0, start_b});
            queue_check("frame_byte", K_BYTE, {8'h00, ch}, {8'h00, got});
            queue_check("stop_bit", K_BIT, 16'd1, {15'd0, stop_b});
        end
        wait_idle(periph_pkg::UART_FRAME_BITS * (prer + 1));
        m_busy = 1'b0;                              // Frame over
        m_done = 1'b1;
        read_check(A_UART_STAT, "stat_done");
    endtask

    task automatic finish_test();
        repeat (2) @(negedge i_mclk);               // Let comparator drain
        test_count++;
        if (err_count == test_err_mark) begin
            $display("test %-12s ok", cur_test);
        end else begin
            $display("test %-12s %0d errors", cur_test, err_count - test_err_mark);
        end
        test_err_mark = err_count;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : main_seq
        periph_pkg::addr_t addr;
        periph_pkg::data_t din;
        periph_pkg::we_t   we;
        logic              line_high;
        int unsigned       r;
        i_rst      = 1'b1;
        i_per_addr = '0;
        i_per_din  = '0;
        i_per_en   = 1'b0;
        i_per_we   = '0;
        i_port0_in = '0;
        i_port1_in = '0;
        {m_dir, m_out, m_pins, m_prer} = '0;
        m_txd       = '0;
        m_busy      = 1'b0;
        m_done      = 1'b0;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        test_err_mark = 0;
        repeat (8) @(posedge i_mclk);
        #5;
        i_rst = 1'b0;

        cur_test = "reset";
        read_check(A_GPIO_DIR, "dir");
        read_check(A_GPIO_OUT, "out");
        read_check(A_GPIO_IN, "in");
        read_check(A_UART_STAT, "stat");
        read_check(A_UART_PRER, "prer");
        check_ports();
        queue_check("txd_idle", K_BIT, 16'd1, {15'd0, o_uart_txd});
        finish_test();

        cur_test = "gpio_rw";
        for (int i = 0; i < N_GPIO_WR; i++) begin
            r    = lcg_next();
            addr = r[0] ? A_GPIO_DIR : A_GPIO_OUT;
            we   = (r[2:1] == 2'b00) ? 2'b11 : r[2:1];      // Reads have no lanes
            din  = r[23:8];
            model_write(addr, din, we);
            read_check(addr, "readback");
            check_ports();
        end
        finish_test();

        cur_test = "gpio_in";
        r = lcg_next();
        model_write(A_GPIO_OUT, r[15:0], 2'b11);
        for (int i = 0; i < N_GPIO_IN; i++) begin
            r = lcg_next();
            model_write(A_GPIO_DIR, r[15:0], 2'b11);
            r = lcg_next();
            drive_pins(r[7:0], r[15:8]);
            repeat (periph_pkg::SYNC_STAGES + 1) @(posedge i_mclk);
            read_check(A_GPIO_IN, "pins");
        end
        finish_test();

        cur_test = "uart_frames";
        model_write(A_UART_PRER, 16'(T4_PRER), 2'b11);
        read_check(A_UART_PRER, "prer");
        for (int f = 0; f < T4_FRAMES; f++) begin
            r = lcg_next();
            uart_frame(r[7:0], 1'b0, 8'h00, T4_PRER);
        end
        finish_test();

        cur_test = "uart_busy";
        model_write(A_UART_PRER, 16'(T5_PRER), 2'b11);
        r = lcg_next();
        uart_frame(r[7:0], 1'b1, ~r[7:0], T5_PRER);
        read_check(A_UART_TXD, "txd_kept");
        line_high = 1'b1;
        repeat (2 * (T5_PRER + 1)) begin            // No second frame
            @(negedge i_mclk);
            line_high = line_high & o_uart_txd;
        end
        queue_check("line_idle", K_BIT, 16'd1, {15'd0, line_high});
        model_write(A_UART_STAT, 16'(1 << periph_pkg::STAT_DONE_BIT), 2'b01);
        read_check(A_UART_STAT, "done_clear");
        finish_test();

        cur_test = "unmapped";
        read_check(14'h0000, "low");
        read_check(periph_pkg::GPIO_BASE + 14'd3, "gpio_gap");
        read_check(periph_pkg::UART_BASE + 14'd3, "uart_gap");
        for (int i = 0; i < 6; i++) begin
            r = lcg_next();
            read_check(r[13:0] | 14'h1000, "random");   // Far above the map
        end
        finish_test();

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
